// ==== source/crypto_pkg.sv ====
package crypto_pkg;

  //////////////////////////////////////////////////
  // Widths and basic types
  //////////////////////////////////////////////////
  localparam int unsigned XLEN = 64;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  typedef enum logic [1:0] {
    FU_BITMANIP = 2'd0,
    FU_SHA2     = 2'd1,
    FU_PRNG     = 2'd2,
    FU_NONE     = 2'd3
  } fu_op_e;

  // Two field layouts of one 32-bit word
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] funct12;       // funct7 and rs2 seen as one field
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
    } unary;
  } instr_u;

  //////////////////////////////////////////////////
  // Internal decode encodings
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    SEL_ZERO     = 2'd0,
    SEL_BITMANIP = 2'd1,
    SEL_SHA2     = 2'd2,
    SEL_PRNG     = 2'd3
  } unit_sel_e;

  typedef enum logic [2:0] {
    BM_BREV8  = 3'd0,
    BM_PACK   = 3'd1,
    BM_PACKH  = 3'd2,
    BM_XPERM4 = 3'd3,
    BM_XPERM8 = 3'd4
  } bitmanip_op_e;

  // Values follow the rs2 field and bit 2 picks SHA-512
  typedef enum logic [2:0] {
    SHA256_SUM0, SHA256_SUM1, SHA256_SIG0, SHA256_SIG1,
    SHA512_SUM0, SHA512_SUM1, SHA512_SIG0, SHA512_SIG1
  } sha_op_e;

  typedef enum logic [1:0] {
    PRNG_IDLE  = 2'd0,
    PRNG_SEED  = 2'd1,
    PRNG_STEP  = 2'd2,
    PRNG_RESET = 2'd3
  } prng_op_e;

  localparam logic [6:0] SHA_FUNCT7        = 7'b0001000;
  localparam word_t      PRNG_DEFAULT_SEED = 64'h9E37_79B9_7F4A_7C15;

endpackage

// ==== source/crypto_decoder.sv ====
`timescale 1ns/1ps

module crypto_decoder
  import crypto_pkg::*;
(
  input  logic         issue_valid_i,
  input  fu_op_e       opcode_i,
  input  instr_u       instr_i,
  output unit_sel_e    unit_sel_o,
  output bitmanip_op_e bm_op_o,
  output sha_op_e      sha_op_o,
  output prng_op_e     prng_op_o,
  output logic         we_o
);

  logic sha_legal;

  // rs2 must stay below 8 and funct7 must match
  assign sha_legal = (instr_i.unary.funct12[11:5] == SHA_FUNCT7) &&
                     (instr_i.unary.funct12[4:3] == 2'b00);

  //////////////////////////////////////////////////
  // Unit select, sub-op and write enable
  //////////////////////////////////////////////////
  always_comb begin
    unit_sel_o = SEL_ZERO;                // Illegal or idle gives zero
    bm_op_o    = BM_BREV8;
    sha_op_o   = SHA256_SUM0;
    prng_op_o  = PRNG_IDLE;               // No state change unless issued
    we_o       = 1'b0;
    if (issue_valid_i) begin
      case (opcode_i)
        FU_BITMANIP: begin
          unit_sel_o = SEL_BITMANIP;
          we_o       = 1'b1;
          case (instr_i.r.funct3)
            3'b000:  bm_op_o = BM_BREV8;
            3'b100:  bm_op_o = BM_PACK;
            3'b111:  bm_op_o = BM_PACKH;
            3'b010:  bm_op_o = BM_XPERM4;
            3'b110:  bm_op_o = BM_XPERM8;
            default: begin
              unit_sel_o = SEL_ZERO;      // Unknown funct3
              we_o       = 1'b0;
            end
          endcase
        end
        FU_SHA2: begin
          if (sha_legal) begin
            unit_sel_o = SEL_SHA2;
            sha_op_o   = sha_op_e'(instr_i.unary.funct12[2:0]);
            we_o       = 1'b1;
          end
        end
        FU_PRNG: begin
          case (instr_i.r.funct3)
            3'b101: prng_op_o = PRNG_SEED;  // No write back
            3'b110: begin
              prng_op_o  = PRNG_STEP;
              unit_sel_o = SEL_PRNG;
              we_o       = 1'b1;
            end
            3'b111: prng_op_o = PRNG_RESET; // No write back
            default: ;
          endcase
        end
        default: ;                        // FU_NONE
      endcase
    end
  end

endmodule

// ==== source/crypto_bitmanip.sv ====
`timescale 1ns/1ps

module crypto_bitmanip
  import crypto_pkg::*;
(
  input  bitmanip_op_e bm_op_i,
  input  word_t        rs1_i,
  input  word_t        rs2_i,
  output word_t        result_o
);

  word_t brev8_res;
  word_t pack_res;
  word_t packh_res;

  always_comb begin
    for (int unsigned i = 0; i < XLEN; i++) begin
      brev8_res[i] = rs1_i[(i & ~32'd7) | (32'd7 - (i & 32'd7))];  // Mirror inside byte
    end
  end

  assign pack_res  = {rs2_i[31:0], rs1_i[31:0]};
  assign packh_res = {48'b0, rs2_i[7:0], rs1_i[7:0]};

  //////////////////////////////////////////////////
  // Crossbar permutation on nibbles (g=0) and bytes (g=1)
  //////////////////////////////////////////////////
  for (genvar g = 0; g < 2; g++) begin : g_xperm
    localparam int unsigned LaneW  = 4 * (g + 1);
    localparam int unsigned NLanes = XLEN / LaneW;

    word_t res;

    always_comb begin
      int unsigned idx;
      res = '0;
      for (int unsigned i = 0; i < NLanes; i++) begin
        idx = 32'(rs2_i[i*LaneW +: LaneW]);
        if (idx < NLanes) begin
          res[i*LaneW +: LaneW] = rs1_i[idx*LaneW +: LaneW];
        end                               // Out of range lane stays zero
      end
    end
  end

  always_comb begin
    case (bm_op_i)
      BM_BREV8:  result_o = brev8_res;
      BM_PACK:   result_o = pack_res;
      BM_PACKH:  result_o = packh_res;
      BM_XPERM4: result_o = g_xperm[0].res;
      BM_XPERM8: result_o = g_xperm[1].res;
      default:   result_o = '0;
    endcase
  end

endmodule

// ==== source/crypto_sha2.sv ====
`timescale 1ns/1ps

module crypto_sha2
  import crypto_pkg::*;
(
  input  sha_op_e sha_op_i,
  input  word_t   rs1_i,
  output word_t   result_o
);

  logic [31:0] w_lo;
  logic [31:0] res32;
  word_t       res64;

  function automatic logic [31:0] ror32(input logic [31:0] x, input int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

  function automatic word_t ror64(input word_t x, input int unsigned n);
    return (x >> n) | (x << (XLEN - n));
  endfunction

  assign w_lo = rs1_i[31:0];              // SHA-256 sees only the low word

  //////////////////////////////////////////////////
  // Rotate and xor networks
  //////////////////////////////////////////////////
  always_comb begin
    res32 = '0;
    res64 = '0;
    case (sha_op_i)
      SHA256_SUM0: res32 = ror32(w_lo, 2) ^ ror32(w_lo, 13) ^ ror32(w_lo, 22);
      SHA256_SUM1: res32 = ror32(w_lo, 6) ^ ror32(w_lo, 11) ^ ror32(w_lo, 25);
      SHA256_SIG0: res32 = ror32(w_lo, 7) ^ ror32(w_lo, 18) ^ (w_lo >> 3);
      SHA256_SIG1: res32 = ror32(w_lo, 17) ^ ror32(w_lo, 19) ^ (w_lo >> 10);
      SHA512_SUM0: res64 = ror64(rs1_i, 28) ^ ror64(rs1_i, 34) ^ ror64(rs1_i, 39);
      SHA512_SUM1: res64 = ror64(rs1_i, 14) ^ ror64(rs1_i, 18) ^ ror64(rs1_i, 41);
      SHA512_SIG0: res64 = ror64(rs1_i, 1) ^ ror64(rs1_i, 8) ^ (rs1_i >> 7);
      SHA512_SIG1: res64 = ror64(rs1_i, 19) ^ ror64(rs1_i, 61) ^ (rs1_i >> 6);
      default: ;
    endcase
  end

  // Bit 2 of the op picks the 64-bit family
  assign result_o = sha_op_i[2] ? res64 : {{32{res32[31]}}, res32};

endmodule

// ==== source/crypto_prng.sv ====
`timescale 1ns/1ps

module crypto_prng
  import crypto_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  prng_op_e prng_op_i,
  input  word_t    seed_i,
  output word_t    rand_o
);

  word_t state_q;
  word_t step_d;

  // xorshift64 with shifts 13, 7, 17
  always_comb begin
    step_d = state_q ^ (state_q << 13);
    step_d = step_d ^ (step_d >> 7);
    step_d = step_d ^ (step_d << 17);
  end

  assign rand_o = step_d;                 // Same value the state takes on a step

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PRNG_DEFAULT_SEED;
    end else begin
      case (prng_op_i)
        PRNG_SEED:  state_q <= (seed_i == '0) ? PRNG_DEFAULT_SEED : seed_i;  // Zero would lock up
        PRNG_STEP:  state_q <= step_d;
        PRNG_RESET: state_q <= PRNG_DEFAULT_SEED;
        default: ;                        // Hold
      endcase
    end
  end

endmodule

// ==== source/crypto_writeback.sv ====
`timescale 1ns/1ps

module crypto_writeback
  import crypto_pkg::*;
#(
  parameter int unsigned IdWidth = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               issue_valid_i,
  input  unit_sel_e          unit_sel_i,
  input  logic               we_i,
  input  word_t              bm_result_i,
  input  word_t              sha_result_i,
  input  word_t              prng_result_i,
  input  logic [IdWidth-1:0] id_i,
  input  reg_idx_t           rd_i,
  output word_t              result_o,
  output logic [IdWidth-1:0] id_o,
  output reg_idx_t           rd_o,
  output logic               valid_o,
  output logic               we_o
);

  word_t result_d;

  always_comb begin
    case (unit_sel_i)
      SEL_BITMANIP: result_d = bm_result_i;
      SEL_SHA2:     result_d = sha_result_i;
      SEL_PRNG:     result_d = prng_result_i;
      default:      result_d = '0;    // Illegal, seed, reset and idle
    endcase
  end

  //////////////////////////////////////////////////
  // Single output stage
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_o <= '0;
      id_o     <= '0;
      rd_o     <= '0;
      valid_o  <= 1'b0;
      we_o     <= 1'b0;
    end else begin
      result_o <= result_d;
      id_o     <= id_i;
      rd_o     <= rd_i;
      valid_o  <= issue_valid_i;         // Every issue returns one result
      we_o     <= we_i;
    end
  end

endmodule

// ==== source/crypto_scalar_fu.sv ====
`timescale 1ns/1ps

module crypto_scalar_fu
  import crypto_pkg::*;
#(
  parameter int unsigned IdWidth = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               issue_valid_i,
  input  fu_op_e             opcode_i,
  input  instr_u             instr_i,
  input  word_t              rs1_i,
  input  word_t              rs2_i,
  input  logic [IdWidth-1:0] id_i,
  output word_t              result_o,
  output logic [IdWidth-1:0] id_o,
  output reg_idx_t           rd_o,
  output logic               valid_o,
  output logic               we_o
);

  unit_sel_e    unit_sel;
  bitmanip_op_e bm_op;
  sha_op_e      sha_op;
  prng_op_e     prng_op;
  logic         we;
  word_t        bm_result;
  word_t        sha_result;
  word_t        prng_result;

  crypto_decoder u_decoder (
    .issue_valid_i (issue_valid_i),
    .opcode_i      (opcode_i),
    .instr_i       (instr_i),
    .unit_sel_o    (unit_sel),
    .bm_op_o       (bm_op),
    .sha_op_o      (sha_op),
    .prng_op_o     (prng_op),
    .we_o          (we)
  );

  //////////////////////////////////////////////////
  // Datapath units
  //////////////////////////////////////////////////
  crypto_bitmanip u_bitmanip (
    .bm_op_i  (bm_op),
    .rs1_i    (rs1_i),
    .rs2_i    (rs2_i),
    .result_o (bm_result)
  );

  crypto_sha2 u_sha2 (
    .sha_op_i (sha_op),
    .rs1_i    (rs1_i),
    .result_o (sha_result)
  );

  crypto_prng u_prng (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .prng_op_i (prng_op),
    .seed_i    (rs1_i),                   // Seed comes in on rs1
    .rand_o    (prng_result)
  );

  crypto_writeback #(
    .IdWidth (IdWidth)
  ) u_writeback (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_valid_i (issue_valid_i),
    .unit_sel_i    (unit_sel),
    .we_i          (we),
    .bm_result_i   (bm_result),
    .sha_result_i  (sha_result),
    .prng_result_i (prng_result),
    .id_i          (id_i),
    .rd_i          (instr_i.r.rd),
    .result_o      (result_o),
    .id_o          (id_o),
    .rd_o          (rd_o),
    .valid_o       (valid_o),
    .we_o          (we_o)
  );

endmodule

// ==== dv/crypto_fu_properties.sv ====
`timescale 1ns/1ps

module crypto_fu_properties
  import crypto_pkg::*;
(
  input logic  clk_i,
  input logic  rst_ni,
  input logic  issue_valid_i,
  input word_t result_o,
  input logic  valid_o,
  input logic  we_o
);

  // One result per issue, one cycle later
  a_valid_follows_issue: assert property (
    @(posedge clk_i) disable iff (!rst_ni) valid_o == $past(issue_valid_i)
  ) else $error("valid_o does not follow issue_valid_i by one cycle");

  a_we_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) we_o |-> valid_o
  ) else $error("we_o high without valid_o");

  // Seed, reset and illegal ops return zero
  a_no_write_zero: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (valid_o && !we_o) |-> (result_o == '0)
  ) else $error("result_o is not zero on a result without write enable");

endmodule

bind crypto_scalar_fu crypto_fu_properties u_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .issue_valid_i (issue_valid_i),
  .result_o      (result_o),
  .valid_o       (valid_o),
  .we_o          (we_o)
);

// ==== include/crypto_ref.svh ====
`ifndef CRYPTO_REF_SVH
`define CRYPTO_REF_SVH

function automatic word_t xorshift_step(input word_t s);
  word_t x;
  x = s ^ (s << 13);
  x = x ^ (x >> 7);
  return x ^ (x << 17);
endfunction

function automatic word_t rotate_right(input word_t x, input int n, input int w);
  word_t mask;
  mask = (w == 64) ? '1 : ((word_t'(1) << w) - 1);
  x = x & mask;
  return ((x >> n) | (x << (w - n))) & mask;
endfunction

function automatic word_t lane_permute(input word_t rs1, input word_t rs2, input int lw);
  word_t r;
  word_t mask;
  int    idx;
  r    = '0;
  mask = (word_t'(1) << lw) - 1;
  for (int i = 0; i < 64 / lw; i++) begin
    idx = int'((rs2 >> (i * lw)) & mask);
    if (idx < 64 / lw) begin
      r |= ((rs1 >> (idx * lw)) & mask) << (i * lw);
    end
  end
  return r;
endfunction

function automatic word_t sha2_expected(input logic [2:0] sel, input word_t x);
  word_t h;
  case (sel)
    3'd0: h = rotate_right(x, 2, 32) ^ rotate_right(x, 13, 32) ^ rotate_right(x, 22, 32);
    3'd1: h = rotate_right(x, 6, 32) ^ rotate_right(x, 11, 32) ^ rotate_right(x, 25, 32);
    3'd2: h = rotate_right(x, 7, 32) ^ rotate_right(x, 18, 32) ^ ((x & 64'hFFFF_FFFF) >> 3);
    3'd3: h = rotate_right(x, 17, 32) ^ rotate_right(x, 19, 32) ^ ((x & 64'hFFFF_FFFF) >> 10);
    3'd4: return rotate_right(x, 28, 64) ^ rotate_right(x, 34, 64) ^ rotate_right(x, 39, 64);
    3'd5: return rotate_right(x, 14, 64) ^ rotate_right(x, 18, 64) ^ rotate_right(x, 41, 64);
    3'd6: return rotate_right(x, 1, 64) ^ rotate_right(x, 8, 64) ^ (x >> 7);
    default: return rotate_right(x, 19, 64) ^ rotate_right(x, 61, 64) ^ (x >> 6);
  endcase
  return {{32{h[31]}}, h[31:0]};          // Sign extend the 32-bit result
endfunction

// Full model of one issue with its own PRNG state
function void model_issue(input fu_op_e op, input instr_u ins, input word_t rs1,
                          input word_t rs2, output word_t result, output logic we);
  static word_t prng_state = PRNG_DEFAULT_SEED;
  result = '0;
  we     = 1'b0;
  case (op)
    FU_BITMANIP: begin
      we = 1'b1;
      case (ins.r.funct3)
        3'b000: for (int i = 0; i < 64; i++) result[i] = rs1[(i / 8) * 8 + 7 - (i % 8)];
        3'b100: result = (rs2 << 32) | (rs1 & 64'hFFFF_FFFF);
        3'b111: result = ((rs2 & 64'hFF) << 8) | (rs1 & 64'hFF);
        3'b010: result = lane_permute(rs1, rs2, 4);
        3'b110: result = lane_permute(rs1, rs2, 8);
        default: we = 1'b0;
      endcase
    end
    FU_SHA2: begin
      if (ins.unary.funct12[11:5] == SHA_FUNCT7 && ins.unary.funct12[4:3] == 2'b00) begin
        result = sha2_expected(ins.unary.funct12[2:0], rs1);
        we     = 1'b1;
      end
    end
    FU_PRNG: begin
      case (ins.r.funct3)
        3'b101: prng_state = (rs1 == '0) ? PRNG_DEFAULT_SEED : rs1;
        3'b110: begin
          prng_state = xorshift_step(prng_state);
          result     = prng_state;
          we         = 1'b1;
        end
        3'b111: prng_state = PRNG_DEFAULT_SEED;
        default: ;
      endcase
    end
    default: ;
  endcase
endfunction

`endif

// ==== dv/tb_crypto_scalar_fu.sv ====
`timescale 1ns/1ps

module tb_crypto_scalar_fu
  import crypto_pkg::*;
();

  localparam int unsigned IdWidth     = 4;
  localparam int unsigned ResetCycles = 10;
  localparam int unsigned NumRandBm   = 200;
  localparam int unsigned NumMixed    = 24;
  // First step, directed bitmanip, sha2 sweep, prng chain and illegal ops
  localparam int unsigned NumIssues     = 1 + 6 + NumRandBm + 24 + 8 + 10 + NumMixed;
  localparam int unsigned TimeoutCycles = NumIssues + ResetCycles + 50;

  logic               clk;
  logic               rst_n;
  logic               issue_valid;
  fu_op_e             opcode;
  instr_u             instr;
  word_t              rs1_val;
  word_t              rs2_val;
  logic [IdWidth-1:0] id_val;
  word_t              result;
  logic [IdWidth-1:0] id_out;
  reg_idx_t           rd_out;
  logic               valid;
  logic               we;

  word_t              rand_state = 64'd55;
  logic [IdWidth-1:0] next_id    = '0;
  int unsigned        cycles     = 0;

  // Scoreboard with one entry per issue
  word_t              exp_result_q[$];
  logic               exp_we_q[$];
  logic [IdWidth-1:0] exp_id_q[$];
  reg_idx_t           exp_rd_q[$];
  int unsigned        exp_cycle_q[$];

  `include "crypto_ref.svh"

  crypto_scalar_fu #(
    .IdWidth (IdWidth)
  ) u_dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .issue_valid_i (issue_valid),
    .opcode_i      (opcode),
    .instr_i       (instr),
    .rs1_i         (rs1_val),
    .rs2_i         (rs2_val),
    .id_i          (id_val),
    .result_o      (result),
    .id_o          (id_out),
    .rd_o          (rd_out),
    .valid_o       (valid),
    .we_o          (we)
  );

  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic word_t next_random();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 7);
    rand_state = rand_state ^ (rand_state << 17);
    return rand_state;
  endfunction

  function automatic reg_idx_t pick_rd();
    word_t w;
    w = next_random();
    return w[4:0];
  endfunction

  function automatic instr_u make_instr(input logic [6:0] f7, input logic [4:0] r2,
                                        input logic [4:0] r1, input logic [2:0] f3,
                                        input reg_idx_t rd);
    instr_u ins;
    ins.r.funct7 = f7;
    ins.r.rs2    = r2;
    ins.r.rs1    = r1;
    ins.r.funct3 = f3;
    ins.r.rd     = rd;
    ins.r.opcode = 7'h0B;                 // Custom-0 major opcode
    return ins;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_rd(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_id(input string name, input logic [IdWidth-1:0] got,
                          input logic [IdWidth-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  // Drive one issue and queue what the reference model expects back
  task automatic issue_op(input fu_op_e op, input instr_u ins, input word_t a, input word_t b);
    word_t exp_result;
    logic  exp_we;
    @(posedge clk);
    #2;
    issue_valid = 1'b1;
    opcode      = op;
    instr       = ins;
    rs1_val     = a;
    rs2_val     = b;
    id_val      = next_id;
    model_issue(op, ins, a, b, exp_result, exp_we);
    exp_result_q.push_back(exp_result);
    exp_we_q.push_back(exp_we);
    exp_id_q.push_back(next_id);
    exp_rd_q.push_back(ins.r.rd);
    exp_cycle_q.push_back(cycles + 1);
    next_id++;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #2;
    issue_valid = 1'b0;
  endtask

  task automatic bitmanip_random();
    word_t      a;
    word_t      b;
    logic [2:0] f3;
    int         pick;
    pick = int'(next_random() % 64'd5);
    case (pick)
      0:       f3 = 3'b000;
      1:       f3 = 3'b100;
      2:       f3 = 3'b111;
      3:       f3 = 3'b010;
      default: f3 = 3'b110;
    endcase
    a = next_random();
    b = next_random();
    if (a[0]) begin
      b = b & 64'h0F0F_0F0F_0F0F_0F0F;    // Half the byte indices in range
    end
    issue_op(FU_BITMANIP, make_instr(7'h00, 5'd2, 5'd1, f3, pick_rd()), a, b);
  endtask

  task automatic sha_random();
    word_t w;
    w = next_random();
    issue_op(FU_SHA2, make_instr(SHA_FUNCT7, {2'b00, w[2:0]}, 5'd1, 3'b001, pick_rd()),
             next_random(), next_random());
  endtask

  //////////////////////////////////////////////////
  // Scoreboard and timeout
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TimeoutCycles) begin
      abort_run($sformatf("Timeout after %0d cycles, the test did not finish", cycles));
    end
  end

  always @(negedge clk) begin
    word_t              e_result;
    logic               e_we;
    logic [IdWidth-1:0] e_id;
    reg_idx_t           e_rd;
    int unsigned        e_cycle;
    if (rst_n && valid) begin
      if (exp_result_q.size() == 0) begin
        abort_run("valid_o was high with no issue outstanding");
      end else begin
        e_result = exp_result_q.pop_front();
        e_we     = exp_we_q.pop_front();
        e_id     = exp_id_q.pop_front();
        e_rd     = exp_rd_q.pop_front();
        e_cycle  = exp_cycle_q.pop_front();
        if (e_cycle != cycles) begin
          abort_run($sformatf("Result for id %0h came in cycle %0d instead of cycle %0d",
                              e_id, cycles, e_cycle));
        end
        check_word("result_o", result, e_result);
        check_id("id_o", id_out, e_id);
        check_rd("rd_o", rd_out, e_rd);
        check_bit("we_o", we, e_we);
      end
    end else if (rst_n && exp_cycle_q.size() > 0 && exp_cycle_q[0] <= cycles) begin
      abort_run("valid_o stayed low while an issue was due");
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    opcode      = FU_NONE;
    instr       = '0;
    rs1_val     = '0;
    rs2_val     = '0;
    id_val      = '0;
    repeat (ResetCycles) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_bit("valid_o", valid, 1'b0);
    check_bit("we_o", we, 1'b0);

    // First step from the reset seed
    issue_op(FU_PRNG, make_instr(7'h00, 5'd0, 5'd0, 3'b110, 5'd3), '0, '0);
    idle_cycle();

    // Directed bitmanip, xperm edge indices
    issue_op(FU_BITMANIP, make_instr(7'h00, 5'd2, 5'd1, 3'b000, 5'd4),
             64'h0123_4567_89AB_CDEF, 64'hFFFF_0000_FFFF_0000);
    issue_op(FU_BITMANIP, make_instr(7'h00, 5'd2, 5'd1, 3'b100, 5'd5),
             64'h1111_2222_3333_4444, 64'h5555_6666_7777_8888);
    issue_op(FU_BITMANIP, make_instr(7'h00, 5'd2, 5'd1, 3'b111, 5'd6),
             64'hDEAD_BEEF_CAFE_F00D, 64'h0123_4567_89AB_CD5A);
    issue_op(FU_BITMANIP, make_instr(7'h00, 5'd2, 5'd1, 3'b010, 5'd7),
             64'h0123_4567_89AB_CDEF, 64'hF0F0_0F0F_EDCB_A987);
    issue_op(FU_BITMANIP, make_instr(7'h00, 5'd2, 5'd1, 3'b110, 5'd8),
             64'h1122_3344_5566_7788, 64'h0708_0807_FF00_0106);
    issue_op(FU_BITMANIP, make_instr(7'h00, 5'd2, 5'd1, 3'b110, 5'd9),
             64'h1122_3344_5566_7788, 64'h0808_0808_0808_0808);
    for (int n = 0; n < NumRandBm; n++) begin
      bitmanip_random();
    end
    idle_cycle();

    // Every SHA-2 function on random, all ones and a negative low word
    for (int s = 0; s < 8; s++) begin
      issue_op(FU_SHA2, make_instr(SHA_FUNCT7, {2'b00, s[2:0]}, 5'd1, 3'b001, pick_rd()),
               next_random(), '0);
      issue_op(FU_SHA2, make_instr(SHA_FUNCT7, {2'b00, s[2:0]}, 5'd1, 3'b001, pick_rd()),
               '1, '0);
      issue_op(FU_SHA2, make_instr(SHA_FUNCT7, {2'b00, s[2:0]}, 5'd1, 3'b001, pick_rd()),
               64'h0000_0000_8000_0001, '0);
    end
    idle_cycle();

    // PRNG seed, chained steps, zero seed and reset
    issue_op(FU_PRNG, make_instr(7'h00, 5'd0, 5'd1, 3'b101, 5'd10), next_random(), '0);
    issue_op(FU_PRNG, make_instr(7'h00, 5'd0, 5'd0, 3'b110, 5'd11), '0, '0);
    issue_op(FU_PRNG, make_instr(7'h00, 5'd0, 5'd0, 3'b110, 5'd12), '0, '0);
    issue_op(FU_PRNG, make_instr(7'h00, 5'd0, 5'd0, 3'b110, 5'd13), '0, '0);
    issue_op(FU_PRNG, make_instr(7'h00, 5'd0, 5'd1, 3'b101, 5'd14), '0, '0);
    issue_op(FU_PRNG, make_instr(7'h00, 5'd0, 5'd0, 3'b110, 5'd15), '0, '0);
    issue_op(FU_PRNG, make_instr(7'h00, 5'd0, 5'd0, 3'b111, 5'd16), next_random(), '0);
    issue_op(FU_PRNG, make_instr(7'h00, 5'd0, 5'd0, 3'b110, 5'd17), '0, '0);
    idle_cycle();

    // Illegal encodings and a step to show the PRNG held
    issue_op(FU_SHA2, make_instr(7'b0001001, 5'd0, 5'd1, 3'b001, 5'd18), next_random(), '0);
    issue_op(FU_SHA2, make_instr(SHA_FUNCT7, 5'd8, 5'd1, 3'b001, 5'd19), next_random(), '0);
    issue_op(FU_SHA2, make_instr(SHA_FUNCT7, 5'd16, 5'd1, 3'b001, 5'd20), next_random(), '0);
    issue_op(FU_BITMANIP, make_instr(7'h00, 5'd2, 5'd1, 3'b001, 5'd21), next_random(), '1);
    issue_op(FU_BITMANIP, make_instr(7'h00, 5'd2, 5'd1, 3'b011, 5'd22), next_random(), '1);
    issue_op(FU_BITMANIP, make_instr(7'h00, 5'd2, 5'd1, 3'b101, 5'd23), next_random(), '1);
    issue_op(FU_PRNG, make_instr(7'h00, 5'd0, 5'd1, 3'b000, 5'd24), next_random(), '0);
    issue_op(FU_PRNG, make_instr(7'h00, 5'd0, 5'd1, 3'b100, 5'd25), next_random(), '0);
    issue_op(FU_NONE, make_instr(7'h7F, 5'd31, 5'd31, 3'b110, 5'd26), next_random(), '1);
    issue_op(FU_PRNG, make_instr(7'h00, 5'd0, 5'd0, 3'b110, 5'd27), '0, '0);
    idle_cycle();

    // Back to back traffic with a gap every fifth slot
    for (int k = 0; k < NumMixed; k++) begin
      case (k % 4)
        0: bitmanip_random();
        1: sha_random();
        2: issue_op(FU_PRNG, make_instr(7'h00, 5'd0, 5'd0, 3'b110, pick_rd()), '0, '0);
        default: issue_op(FU_NONE, make_instr(7'h01, 5'd3, 5'd4, 3'b010, pick_rd()),
                          next_random(), next_random());
      endcase
      if (k % 5 == 4) begin
        idle_cycle();
      end
    end
    idle_cycle();

    repeat (2) @(negedge clk);
    if (exp_result_q.size() != 0) begin
      abort_run($sformatf("%0d results never came back", exp_result_q.size()));
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
+incdir+include
source/crypto_pkg.sv
source/crypto_decoder.sv
source/crypto_bitmanip.sv
source/crypto_sha2.sv
source/crypto_prng.sv
source/crypto_writeback.sv
source/crypto_scalar_fu.sv
dv/crypto_fu_properties.sv
dv/tb_crypto_scalar_fu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the crypto FU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f \
  --top-module tb_crypto_scalar_fu -o sim_crypto_fu

out=$(./obj_dir/sim_crypto_fu 2>&1 || true)
printf '%s\n' "$out"

# Fails the script unless the pass line was printed
printf '%s\n' "$out" | grep -qx "NO ERRORS"
